//--- include/ilkn_rx_macros.svh
`ifndef ILKN_RX_MACROS_SVH
`define ILKN_RX_MACROS_SVH

// words delivered per clock on the raw lane-aligned stream
// filter and packer datapaths are built around two
`define ILKN_WORDS 2

// full word width, top bit is the framing/control flag
`define ILKN_WORD_W 65

// number of channels pulled out of the stream
`define ILKN_NUM_CHANS 2

// channel numbers handed to the filters
`define ILKN_CHAN_A 8'h01
`define ILKN_CHAN_B 8'h05

// packer buffer size in words
`define ILKN_PACK_DEPTH 4

`endif

//--- hdl/ilkn_rx_pkg.sv
`include "ilkn_rx_macros.svh"

package ilkn_rx_pkg;

	////////////////////////////////////////////////////////////
	// field widths
	////////////////////////////////////////////////////////////

	// payload bits below the framing flag
	localparam int BODY_W = `ILKN_WORD_W - 1;
	// end of packet flag plus valid byte count
	localparam int EOP_W  = 4;
	localparam int RSVD_W = 17;
	localparam int CHAN_W = 8;
	localparam int CRC_W  = 32;
	// 0, 1 or 2 words
	localparam int CNT_W  = 2;

	////////////////////////////////////////////////////////////
	// word views
	////////////////////////////////////////////////////////////

	// control word layout, msb first
	// ctl/burst/sop at the top, crc24 region at the bottom
	typedef struct packed {
		logic              ctl;
		// burst control when set, idle otherwise
		logic              burst;
		logic              sop;
		logic [EOP_W-1:0]  eop_fmt;
		logic [RSVD_W-1:0] rsvd;
		logic [CHAN_W-1:0] chan;
		logic [CRC_W-1:0]  crc;
	} ilkn_ctl_t;

	// same 64 bits read as payload or as control fields
	// the framing flag picks which view means anything
	typedef union packed {
		logic [BODY_W-1:0] data;
		ilkn_ctl_t         ctl;
	} ilkn_body_u;

	// one 65 bit word on the wire
	typedef struct packed {
		logic       is_ctl;
		ilkn_body_u body;
	} ilkn_word_t;

	// element 1 arrived first
	typedef ilkn_word_t [`ILKN_WORDS-1:0] ilkn_pair_t;

	// valid words in a pair
	typedef logic [CNT_W-1:0] ilkn_cnt_t;

endpackage

//--- hdl/ilkn_chan_filter.sv
`timescale 1ns/1ns
`include "ilkn_rx_macros.svh"

// pulls the words of one channel out of the raw 2 word stream
// fixed six cycle pipeline, no handshake since the source never stalls
module ilkn_chan_filter (
	input  logic                                clk,
	input  logic                                arst,
	input  logic                                rx_valid,
	input  ilkn_rx_pkg::ilkn_pair_t             rx_words,
	input  logic [ilkn_rx_pkg::CHAN_W-1:0]      chan_id,
	output ilkn_rx_pkg::ilkn_pair_t             chan_words,
	output ilkn_rx_pkg::ilkn_cnt_t              chan_cnt
);

	////////////////////////////////////////////////////////////
	// stage 1, input register
	////////////////////////////////////////////////////////////
	logic                    s1_valid;
	ilkn_rx_pkg::ilkn_pair_t s1_words;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= rx_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_words <= rx_words;
	end

	////////////////////////////////////////////////////////////
	// stage 2, start and stop flags
	////////////////////////////////////////////////////////////
	// chan and burst bits only mean something on burst control words
	// idle and burst control words both carry end info for the prior data
	logic [`ILKN_WORDS-1:0]  chan_match;
	logic [`ILKN_WORDS-1:0]  burst_info;
	logic [`ILKN_WORDS-1:0]  end_info;
	logic [`ILKN_WORDS-1:0]  start_q;
	logic [`ILKN_WORDS-1:0]  stop_q;
	logic                    s2_valid;
	ilkn_rx_pkg::ilkn_pair_t s2_words;

	always_comb begin
		for (int i = 0; i < `ILKN_WORDS; i++) begin
			chan_match[i] = s1_words[i].body.ctl.chan == chan_id;
			burst_info[i] = s1_words[i].is_ctl & s1_words[i].body.ctl.ctl &
				s1_words[i].body.ctl.burst;
			end_info[i]   = s1_words[i].is_ctl & s1_words[i].body.ctl.ctl;
		end
	end

	// a word that closes and reopens our channel is only a start
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			start_q  <= '0;
			stop_q   <= '0;
			s2_valid <= 1'b0;
		end else begin
			start_q  <= chan_match & burst_info & {`ILKN_WORDS{s1_valid}};
			stop_q   <= end_info & ~(chan_match & burst_info) & {`ILKN_WORDS{s1_valid}};
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		s2_words <= s1_words;
	end

	////////////////////////////////////////////////////////////
	// stage 3, membership and sop mask
	////////////////////////////////////////////////////////////
	logic                    in_burst;
	logic                    mine_hi;
	logic                    mine_lo;
	logic                    mine_after;
	logic [`ILKN_WORDS-1:0]  mine_q;
	logic [`ILKN_WORDS-1:0]  s3_start;
	ilkn_rx_pkg::ilkn_pair_t sop_masked;
	ilkn_rx_pkg::ilkn_pair_t s3_words;

	// upper word first, then lower, then what carries to the next beat
	// a stop word is still ours, the word after it is not
	assign mine_hi    = in_burst | start_q[1];
	assign mine_lo    = (mine_hi & ~stop_q[1]) | start_q[0];
	assign mine_after = mine_lo & ~stop_q[0];

	// sop on a stop word belongs to some other channel
	always_comb begin
		sop_masked = s2_words;
		for (int i = 0; i < `ILKN_WORDS; i++) begin
			if (stop_q[i]) begin
				sop_masked[i].body.ctl.sop = 1'b0;
			end
		end
	end

	// idle beats leave membership where it was
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			mine_q   <= '0;
			in_burst <= 1'b0;
			s3_start <= '0;
		end else begin
			mine_q   <= {mine_hi, mine_lo} & {`ILKN_WORDS{s2_valid}};
			in_burst <= s2_valid ? mine_after : in_burst;
			s3_start <= start_q;
		end
	end

	always_ff @(posedge clk) begin
		s3_words <= sop_masked;
	end

	////////////////////////////////////////////////////////////
	// stage 4, count and eop mask
	////////////////////////////////////////////////////////////
	ilkn_rx_pkg::ilkn_cnt_t  s4_cnt;
	logic                    s4_mine_hi;
	ilkn_rx_pkg::ilkn_pair_t eop_masked;
	ilkn_rx_pkg::ilkn_pair_t s4_words;

	// eop on a start word refers to the burst before it
	always_comb begin
		eop_masked = s3_words;
		for (int i = 0; i < `ILKN_WORDS; i++) begin
			if (s3_start[i]) begin
				eop_masked[i].body.ctl.eop_fmt = '0;
			end
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			s4_cnt     <= '0;
			s4_mine_hi <= 1'b0;
		end else begin
			s4_cnt     <= {1'b0, mine_q[1]} + {1'b0, mine_q[0]};
			s4_mine_hi <= mine_q[1];
		end
	end

	always_ff @(posedge clk) begin
		s4_words <= eop_masked;
	end

	////////////////////////////////////////////////////////////
	// stage 5, left-align selection
	////////////////////////////////////////////////////////////
	ilkn_rx_pkg::ilkn_cnt_t  s5_cnt;
	ilkn_rx_pkg::ilkn_pair_t s5_words;

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			s5_cnt <= '0;
		end else begin
			s5_cnt <= s4_cnt;
		end
	end

	// lone lower word slides up into element 1
	always_ff @(posedge clk) begin
		s5_words[1] <= s4_mine_hi ? s4_words[1] : s4_words[0];
		s5_words[0] <= s4_words[0];
	end

	////////////////////////////////////////////////////////////
	// stage 6, output register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			chan_cnt <= '0;
		end else begin
			chan_cnt <= s5_cnt;
		end
	end

	// zero the slots we do not fill
	always_ff @(posedge clk) begin
		chan_words[1] <= (s5_cnt != 2'd0) ? s5_words[1] : '0;
		chan_words[0] <= (s5_cnt == 2'd2) ? s5_words[0] : '0;
	end

endmodule

//--- hdl/ilkn_chan_packer.sv
`timescale 1ns/1ns
`include "ilkn_rx_macros.svh"

// gathers 0/1/2 words per clock into valid/ready beats
// input cannot stall, so a full buffer drops and flags overflow
module ilkn_chan_packer (
	input  logic                    clk,
	input  logic                    arst,
	input  ilkn_rx_pkg::ilkn_pair_t in_words,
	input  ilkn_rx_pkg::ilkn_cnt_t  in_cnt,
	input  logic                    out_ready,
	output logic                    out_valid,
	output ilkn_rx_pkg::ilkn_pair_t out_words,
	output ilkn_rx_pkg::ilkn_cnt_t  out_cnt,
	output logic                    overflow
);

	localparam int DEPTH  = `ILKN_PACK_DEPTH;
	localparam int FILL_W = $clog2(DEPTH + 1);
	localparam int IDX_W  = $clog2(DEPTH);

	// entry 0 is the oldest word
	ilkn_rx_pkg::ilkn_word_t word_q [DEPTH];
	ilkn_rx_pkg::ilkn_word_t word_n [DEPTH];
	logic [FILL_W-1:0]       fill_q;
	logic [FILL_W-1:0]       fill_n;
	logic [IDX_W-1:0]        wr_idx;
	ilkn_rx_pkg::ilkn_cnt_t  ready_cnt;
	ilkn_rx_pkg::ilkn_cnt_t  hold_q;
	ilkn_rx_pkg::ilkn_cnt_t  pop_cnt;
	logic                    head_eop;
	logic                    drop;

	////////////////////////////////////////////////////////////
	// output beat
	////////////////////////////////////////////////////////////
	// a lone end-of-packet control word goes out by itself
	assign head_eop = word_q[0].is_ctl & word_q[0].body.ctl.ctl &
		(word_q[0].body.ctl.eop_fmt != '0);

	always_comb begin
		if (fill_q >= FILL_W'(2)) begin
			ready_cnt = 2'd2;
		end else if (fill_q == FILL_W'(1) && head_eop) begin
			ready_cnt = 2'd1;
		end else begin
			ready_cnt = 2'd0;
		end
	end

	// a stalled beat keeps its size even if a second word shows up
	assign out_cnt   = (hold_q != 2'd0) ? hold_q : ready_cnt;
	assign out_valid = out_cnt != 2'd0;

	assign out_words[1] = out_valid ? word_q[0] : '0;
	assign out_words[0] = (out_cnt == 2'd2) ? word_q[1] : '0;

	// words leaving this cycle
	assign pop_cnt = out_ready ? out_cnt : 2'd0;

	////////////////////////////////////////////////////////////
	// buffer update
	////////////////////////////////////////////////////////////
	always_comb begin
		word_n = word_q;
		fill_n = fill_q - FILL_W'(pop_cnt);
		drop   = 1'b0;
		wr_idx = '0;

		// shift out what the sink took
		case (pop_cnt)
			2'd1: begin
				for (int j = 0; j < DEPTH - 1; j++) begin
					word_n[j] = word_q[j + 1];
				end
			end
			2'd2: begin
				for (int j = 0; j < DEPTH - 2; j++) begin
					word_n[j] = word_q[j + 2];
				end
			end
			default: begin
			end
		endcase

		// append first arrival, then the second
		if (in_cnt != 2'd0) begin
			if (fill_n < FILL_W'(DEPTH)) begin
				wr_idx         = fill_n[IDX_W-1:0];
				word_n[wr_idx] = in_words[1];
				fill_n         = fill_n + FILL_W'(1);
			end else begin
				drop = 1'b1;
			end
		end
		if (in_cnt == 2'd2) begin
			if (fill_n < FILL_W'(DEPTH)) begin
				wr_idx         = fill_n[IDX_W-1:0];
				word_n[wr_idx] = in_words[0];
				fill_n         = fill_n + FILL_W'(1);
			end else begin
				drop = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			fill_q   <= '0;
			hold_q   <= '0;
			overflow <= 1'b0;
		end else begin
			fill_q <= fill_n;
			hold_q <= (out_valid & ~out_ready) ? out_cnt : 2'd0;
			// sticky until reset
			if (drop) begin
				overflow <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		word_q <= word_n;
	end

endmodule

//--- hdl/ilkn_rx_chan_top.sv
`timescale 1ns/1ns
`include "ilkn_rx_macros.svh"

// channel extraction, one filter and one packer per channel
module ilkn_rx_chan_top (
	input  logic                                                   clk,
	input  logic                                                   arst,
	input  logic                                                   rx_valid,
	input  logic [`ILKN_WORDS*`ILKN_WORD_W-1:0]                    rx_words,
	input  logic [`ILKN_NUM_CHANS-1:0]                             out_ready,
	output logic [`ILKN_NUM_CHANS-1:0]                             out_valid,
	output logic [`ILKN_NUM_CHANS-1:0][`ILKN_WORDS*`ILKN_WORD_W-1:0] out_words,
	output logic [`ILKN_NUM_CHANS-1:0][ilkn_rx_pkg::CNT_W-1:0]     out_cnt,
	output logic [`ILKN_NUM_CHANS-1:0]                             overflow
);

	// index 0 is channel A
	localparam logic [`ILKN_NUM_CHANS-1:0][ilkn_rx_pkg::CHAN_W-1:0] CHAN_IDS =
		{`ILKN_CHAN_B, `ILKN_CHAN_A};

	// raw pair, upper word arrived first
	ilkn_rx_pkg::ilkn_pair_t raw_pair;

	assign raw_pair = ilkn_rx_pkg::ilkn_pair_t'(rx_words);

	////////////////////////////////////////////////////////////
	// per channel path
	////////////////////////////////////////////////////////////
	for (genvar c = 0; c < `ILKN_NUM_CHANS; c++) begin : g_chan
		ilkn_rx_pkg::ilkn_pair_t flt_words;
		ilkn_rx_pkg::ilkn_cnt_t  flt_cnt;
		ilkn_rx_pkg::ilkn_pair_t pk_words;

		// every filter watches the whole stream
		ilkn_chan_filter u_filter (
			.clk        (clk),
			.arst       (arst),
			.rx_valid   (rx_valid),
			.rx_words   (raw_pair),
			.chan_id    (CHAN_IDS[c]),
			.chan_words (flt_words),
			.chan_cnt   (flt_cnt)
		);

		ilkn_chan_packer u_packer (
			.clk       (clk),
			.arst      (arst),
			.in_words  (flt_words),
			.in_cnt    (flt_cnt),
			.out_ready (out_ready[c]),
			.out_valid (out_valid[c]),
			.out_words (pk_words),
			.out_cnt   (out_cnt[c]),
			.overflow  (overflow[c])
		);

		assign out_words[c] = pk_words;
	end

endmodule

//--- sim/ilkn_rx_chan_sva.sv
`timescale 1ns/1ns
`include "ilkn_rx_macros.svh"

// filter sanity checks bound into every ilkn_chan_filter
module ilkn_rx_chan_sva (
	input logic                    clk,
	input logic                    arst,
	input logic                    rx_valid,
	input ilkn_rx_pkg::ilkn_pair_t rx_words,
	input logic [`ILKN_WORDS-1:0]  start_q,
	input logic [`ILKN_WORDS-1:0]  stop_q,
	input ilkn_rx_pkg::ilkn_cnt_t  chan_cnt
);

	// framing flags of the raw words on valid beats
	// the start and stop flags line up two clocks later
	logic [`ILKN_WORDS-1:0] raw_ctl;

	assign raw_ctl = {rx_words[1].is_ctl, rx_words[0].is_ctl} & {`ILKN_WORDS{rx_valid}};

	stop_on_ctl: assert property (@(posedge clk) disable iff (arst)
		(stop_q & ~$past(raw_ctl, 2)) == '0)
		else $error("stop flagged on a word that was no valid control word, stop_q %h",
			stop_q);

	start_on_ctl: assert property (@(posedge clk) disable iff (arst)
		(start_q & ~$past(raw_ctl, 2)) == '0)
		else $error("start flagged on a word that was no valid control word, start_q %h",
			start_q);

	// at most two words per beat
	// nothing at all for a beat that had rx_valid low
	cnt_max: assert property (@(posedge clk) disable iff (arst)
		chan_cnt <= ($past(rx_valid, 6) ? 2'd2 : 2'd0))
		else $error("chan_cnt too large for its beat, %h", chan_cnt);

endmodule

bind ilkn_chan_filter ilkn_rx_chan_sva u_sva (
	.clk      (clk),
	.arst     (arst),
	.rx_valid (rx_valid),
	.rx_words (rx_words),
	.start_q  (start_q),
	.stop_q   (stop_q),
	.chan_cnt (chan_cnt)
);

//--- sim/ilkn_rx_chan_tb.sv
`timescale 1ns/1ns
`include "ilkn_rx_macros.svh"

module ilkn_rx_chan_tb;

	localparam int N = `ILKN_NUM_CHANS;
	// driven beats per test, idle gaps included
	localparam int TOTAL_BEATS = 1 + 4 + 6 + 3 + 8 + 6;
	localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20;
	localparam int DRAIN_LIMIT = 40;

	logic                                         clk;
	logic                                         arst;
	logic                                         rx_valid;
	logic [`ILKN_WORDS*`ILKN_WORD_W-1:0]          rx_words;
	logic [N-1:0]                                 out_ready;
	logic [N-1:0]                                 out_valid;
	logic [N-1:0][`ILKN_WORDS*`ILKN_WORD_W-1:0]   out_words;
	logic [N-1:0][ilkn_rx_pkg::CNT_W-1:0]         out_cnt;
	logic [N-1:0]                                 overflow;

	integer seed = 32'h6bdd;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	// index 0 is channel A, same order as the top
	logic [7:0] chan_ids [N] = '{`ILKN_CHAN_A, `ILKN_CHAN_B};
	// expected words per channel, oldest first
	ilkn_rx_pkg::ilkn_word_t exp_q [N][$];
	logic in_burst_m [N];
	logic check_en [N];
	// last beat seen stalled, for the stability check
	logic stalled [N];
	ilkn_rx_pkg::ilkn_pair_t held_words [N];
	ilkn_rx_pkg::ilkn_cnt_t held_cnt [N];

	ilkn_rx_chan_top u_ilkn_rx_chan_top (
		.clk       (clk),
		.arst      (arst),
		.rx_valid  (rx_valid),
		.rx_words  (rx_words),
		.out_ready (out_ready),
		.out_valid (out_valid),
		.out_words (out_words),
		.out_cnt   (out_cnt),
		.overflow  (overflow)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////
	task automatic compare_word(input string name, input ilkn_rx_pkg::ilkn_word_t got,
			input ilkn_rx_pkg::ilkn_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_cnt(input string name, input ilkn_rx_pkg::ilkn_cnt_t got,
			input ilkn_rx_pkg::ilkn_cnt_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// word builders
	////////////////////////////////////////////////////////////
	function automatic ilkn_rx_pkg::ilkn_word_t data_word();
		ilkn_rx_pkg::ilkn_word_t w;
		w = '0;
		w.body.data = {$random(seed), $random(seed)};
		return w;
	endfunction

	// burst control word, crc field filled with noise
	function automatic ilkn_rx_pkg::ilkn_word_t burst_word(input logic [7:0] chan,
			input logic sop, input logic [3:0] eop);
		ilkn_rx_pkg::ilkn_word_t w;
		w = '0;
		w.is_ctl = 1'b1;
		w.body.ctl.ctl = 1'b1;
		w.body.ctl.burst = 1'b1;
		w.body.ctl.sop = sop;
		w.body.ctl.eop_fmt = eop;
		w.body.ctl.chan = chan;
		w.body.ctl.crc = $random(seed);
		return w;
	endfunction

	function automatic ilkn_rx_pkg::ilkn_word_t idle_word(input logic [3:0] eop);
		ilkn_rx_pkg::ilkn_word_t w;
		w = '0;
		w.is_ctl = 1'b1;
		w.body.ctl.ctl = 1'b1;
		w.body.ctl.eop_fmt = eop;
		w.body.ctl.crc = $random(seed);
		return w;
	endfunction

	// a word the packer sends out on its own
	function automatic logic flushable(input ilkn_rx_pkg::ilkn_word_t w);
		return w.is_ctl & w.body.ctl.ctl & (w.body.ctl.eop_fmt != 4'h0);
	endfunction

	////////////////////////////////////////////////////////////
	// reference model, membership rules per channel
	////////////////////////////////////////////////////////////
	task automatic model_word(input int c, input ilkn_rx_pkg::ilkn_word_t w);
		logic is_start;
		logic is_stop;
		ilkn_rx_pkg::ilkn_word_t m;
		is_start = w.is_ctl & w.body.ctl.ctl & w.body.ctl.burst &
			(w.body.ctl.chan == chan_ids[c]);
		is_stop = w.is_ctl & w.body.ctl.ctl & ~is_start;
		m = w;
		// close and reopen on one word counts as start only
		if (is_start) begin
			m.body.ctl.eop_fmt = 4'h0;
			exp_q[c].push_back(m);
			in_burst_m[c] = 1'b1;
		end else if (in_burst_m[c]) begin
			if (is_stop) begin
				m.body.ctl.sop = 1'b0;
				in_burst_m[c] = 1'b0;
			end
			exp_q[c].push_back(m);
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	// first word goes in the upper slot
	task automatic drive_beat(input ilkn_rx_pkg::ilkn_word_t first,
			input ilkn_rx_pkg::ilkn_word_t second);
		@(posedge clk);
		#1;
		rx_valid = 1'b1;
		rx_words = {first, second};
		for (int c = 0; c < N; c++) begin
			model_word(c, first);
			model_word(c, second);
		end
	endtask

	// words on the bus with rx_valid low must be ignored
	task automatic gap_beat(input ilkn_rx_pkg::ilkn_word_t first,
			input ilkn_rx_pkg::ilkn_word_t second);
		@(posedge clk);
		#1;
		rx_valid = 1'b0;
		rx_words = {first, second};
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) gap_beat('0, '0);
	endtask

	function automatic int pending();
		int total;
		total = 0;
		for (int c = 0; c < N; c++) begin
			total += exp_q[c].size();
		end
		return total;
	endfunction

	task automatic wait_drain();
		int waited;
		waited = 0;
		idle_cycles(1);
		while (pending() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (pending() != 0) begin
			errors++;
			$display("%0d expected words never came out within %0d cycles",
				pending(), DRAIN_LIMIT);
		end
		// quiet stretch so stray beats get caught by the monitor
		idle_cycles(8);
	endtask

	task automatic finish_test(input string name, input int err0);
		tests_run++;
		$display("test %s finished with %0d mismatches", name, errors - err0);
	endtask

	////////////////////////////////////////////////////////////
	// monitor, sampled mid cycle where outputs are settled
	////////////////////////////////////////////////////////////
	task automatic pop_beat(input int c, input ilkn_rx_pkg::ilkn_pair_t beat,
			input ilkn_rx_pkg::ilkn_cnt_t cnt);
		if (exp_q[c].size() == 0) begin
			errors++;
			$display("channel %0d delivered a beat while no word was expected", c);
		end else begin
			// a single word beat is only legal for a lone eop control word
			if (exp_q[c].size() == 1) begin
				compare_cnt($sformatf("out_cnt[%0d]", c), cnt, 2'd1);
			end else if (!flushable(exp_q[c][0])) begin
				compare_cnt($sformatf("out_cnt[%0d]", c), cnt, 2'd2);
			end
			compare_word($sformatf("out_words[%0d][1]", c), beat[1], exp_q[c].pop_front());
			if (cnt == 2'd2 && exp_q[c].size() != 0) begin
				compare_word($sformatf("out_words[%0d][0]", c), beat[0],
					exp_q[c].pop_front());
			end
		end
	endtask

	always @(negedge clk) begin
		ilkn_rx_pkg::ilkn_pair_t beat;
		ilkn_rx_pkg::ilkn_cnt_t cnt;
		for (int c = 0; c < N; c++) begin
			beat = ilkn_rx_pkg::ilkn_pair_t'(out_words[c]);
			cnt = out_cnt[c];
			if (!arst && check_en[c]) begin
				// a stalled beat must hold still until taken
				if (stalled[c]) begin
					if (!out_valid[c]) begin
						errors++;
						$display("channel %0d dropped out_valid before the beat was taken", c);
					end
					compare_word($sformatf("out_words[%0d][1]", c), beat[1], held_words[c][1]);
					compare_word($sformatf("out_words[%0d][0]", c), beat[0], held_words[c][0]);
					compare_cnt($sformatf("out_cnt[%0d]", c), cnt, held_cnt[c]);
				end
				if (out_valid[c] && out_ready[c]) begin
					pop_beat(c, beat, cnt);
				end
			end
			stalled[c] = out_valid[c] & ~out_ready[c];
			held_words[c] = beat;
			held_cnt[c] = cnt;
		end
	end

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////
	task automatic check_reset_values();
		int err0;
		err0 = errors;
		for (int c = 0; c < N; c++) begin
			compare_bit($sformatf("out_valid[%0d]", c), out_valid[c], 1'b0);
			compare_cnt($sformatf("out_cnt[%0d]", c), out_cnt[c], 2'd0);
			compare_bit($sformatf("overflow[%0d]", c), overflow[c], 1'b0);
		end
		idle_cycles(1);
		finish_test("reset_values", err0);
	endtask

	task automatic single_burst();
		int err0;
		err0 = errors;
		drive_beat(burst_word(`ILKN_CHAN_A, 1'b1, 4'h7), data_word());
		drive_beat(data_word(), data_word());
		drive_beat(data_word(), data_word());
		// trailing idle with no eop lies outside any burst
		drive_beat(idle_word(4'hb), idle_word(4'h0));
		wait_drain();
		finish_test("single_burst", err0);
	endtask

	task automatic interleaved_bursts();
		int err0;
		err0 = errors;
		drive_beat(burst_word(`ILKN_CHAN_A, 1'b1, 4'h3), data_word());
		// lower word closes A and opens B
		drive_beat(data_word(), burst_word(`ILKN_CHAN_B, 1'b1, 4'h9));
		drive_beat(data_word(), data_word());
		// upper word closes B and opens A
		drive_beat(burst_word(`ILKN_CHAN_A, 1'b1, 4'ha), data_word());
		drive_beat(idle_word(4'hc), burst_word(`ILKN_CHAN_B, 1'b1, 4'h2));
		drive_beat(data_word(), idle_word(4'hd));
		wait_drain();
		finish_test("interleaved_bursts", err0);
	endtask

	task automatic reopen_same_chan();
		int err0;
		err0 = errors;
		drive_beat(burst_word(`ILKN_CHAN_A, 1'b1, 4'h1), data_word());
		drive_beat(burst_word(`ILKN_CHAN_A, 1'b1, 4'h6), data_word());
		drive_beat(data_word(), idle_word(4'he));
		wait_drain();
		finish_test("reopen_same_chan", err0);
	endtask

	task automatic valid_gaps();
		int err0;
		err0 = errors;
		drive_beat(burst_word(`ILKN_CHAN_B, 1'b1, 4'h4), data_word());
		// control words here would break membership if seen
		gap_beat(burst_word(`ILKN_CHAN_A, 1'b1, 4'h0), idle_word(4'hf));
		gap_beat(idle_word(4'h8), data_word());
		gap_beat(data_word(), data_word());
		drive_beat(data_word(), data_word());
		gap_beat(idle_word(4'h5), idle_word(4'h5));
		gap_beat(data_word(), burst_word(`ILKN_CHAN_B, 1'b1, 4'h3));
		drive_beat(data_word(), idle_word(4'h6));
		wait_drain();
		finish_test("valid_gaps", err0);
	endtask

	// runs last, channel A is left stalled and overflowed
	task automatic backpressure();
		int err0;
		err0 = errors;
		@(posedge clk);
		#1;
		out_ready[0] = 1'b0;
		// four words fit the buffer
		drive_beat(burst_word(`ILKN_CHAN_A, 1'b1, 4'h2), data_word());
		drive_beat(data_word(), idle_word(4'h9));
		idle_cycles(14);
		compare_bit("out_valid[0]", out_valid[0], 1'b1);
		compare_bit("overflow[0]", overflow[0], 1'b0);
		@(posedge clk);
		#1;
		out_ready[0] = 1'b1;
		wait_drain();
		// eight words cannot fit, drops are expected from here on
		check_en[0] = 1'b0;
		out_ready[0] = 1'b0;
		drive_beat(burst_word(`ILKN_CHAN_A, 1'b1, 4'h5), data_word());
		drive_beat(data_word(), data_word());
		drive_beat(data_word(), data_word());
		drive_beat(data_word(), idle_word(4'ha));
		idle_cycles(12);
		compare_bit("overflow[0]", overflow[0], 1'b1);
		idle_cycles(4);
		compare_bit("overflow[0]", overflow[0], 1'b1);
		compare_bit("overflow[1]", overflow[1], 1'b0);
		exp_q[0].delete();
		finish_test("backpressure", err0);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////
	initial begin
		arst = 1'b1;
		rx_valid = 1'b0;
		rx_words = '0;
		out_ready = '1;
		for (int c = 0; c < N; c++) begin
			in_burst_m[c] = 1'b0;
			check_en[c] = 1'b1;
			stalled[c] = 1'b0;
		end
		repeat (3) @(posedge clk);
		#1;
		arst = 1'b0;
		check_reset_values();
		single_burst();
		interleaved_bursts();
		reopen_same_chan();
		valid_gaps();
		backpressure();
		$display("tests run %0d, checks %0d, mismatches %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
		$display("Errors found");
		$finish;
	end

endmodule

//--- ilkn_rx_chan_top.f
+incdir+include
hdl/ilkn_rx_pkg.sv
hdl/ilkn_chan_filter.sv
hdl/ilkn_chan_packer.sv
hdl/ilkn_rx_chan_top.sv
sim/ilkn_rx_chan_sva.sv
sim/ilkn_rx_chan_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the channel extraction testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f ilkn_rx_chan_top.f \
	--top-module ilkn_rx_chan_tb \
	-o ilkn_rx_chan_sim

# a failed assertion stops the run early, the log decides the result
./obj_dir/ilkn_rx_chan_sim > sim.log 2>&1 || true
cat sim.log

grep -qx "No errors" sim.log
